// File: rtl/motion_defines.svh
`ifndef MOTION_DEFINES_SVH
`define MOTION_DEFINES_SVH

// SPI frame: 8-bit opcode then 32 data bits
`define FRAME_BITS 40

`define OP_MOVE   8'h01
`define OP_ENABLE 8'h02

// Records held in the move queue, power of two
`define MOVE_FIFO_DEPTH 4

// Step high time in clock cycles
`define STEP_PULSE_CYCLES 4

// Shortest rise to rise spacing, shorter requests are raised to it
`define MIN_STEP_PERIOD 8

`endif

// File: rtl/motion_pkg.sv
package motion_pkg;

  typedef logic [14:0] step_count_t;   // Steps in one move
  typedef logic [15:0] step_period_t;  // Clocks from one step rise to the next

  typedef logic signed [31:0] position_t;

  // Same layout as the frame data field: {dir, count, period}
  typedef logic [31:0] move_rec_t;

  typedef logic [7:0] opcode_t;

  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_SHIFT,
    SPI_DONE   // All bits in, waiting for CS to rise
  } spi_state_t;

  typedef enum logic [1:0] {
    STEP_IDLE,
    STEP_PULSE,
    STEP_GAP
  } step_state_t;

endpackage

// File: rtl/spi_cmd_decoder.sv
`timescale 1ns/1ns
`include "motion_defines.svh"

module spi_cmd_decoder (
  input  logic                  CLK,
  input  logic                  resetn,
  input  logic                  sck,
  input  logic                  cs,
  input  logic                  copi,
  output logic                  cipo,
  input  motion_pkg::position_t position,
  output logic                  move_valid,
  input  logic                  move_ready,
  output motion_pkg::move_rec_t move_data,
  output logic                  enable,
  output logic                  cmd_overrun
);

  logic [2:0]             sck_sync;
  logic [2:0]             cs_sync;
  logic [1:0]             copi_sync;
  logic                   sck_rise;
  logic                   sck_fall;
  logic                   cs_rise;
  logic                   cs_fall;
  motion_pkg::spi_state_t state;
  logic [5:0]             bit_cnt;
  logic [`FRAME_BITS-1:0] rx_shift;
  logic [31:0]            tx_shift;
  motion_pkg::opcode_t    opcode;
  logic                   frame_ok;
  logic                   move_frame;
  logic                   load_move;

  // Two sync flops, third one for edge detect
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_sync  <= '0;
      cs_sync   <= '1;  // CS idles high
      copi_sync <= '0;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_sync   <= {cs_sync[1:0], cs};
      copi_sync <= {copi_sync[0], copi};
    end
  end

  assign sck_rise = sck_sync[1] & ~sck_sync[2];
  assign sck_fall = ~sck_sync[1] & sck_sync[2];
  assign cs_rise  = cs_sync[1] & ~cs_sync[2];
  assign cs_fall  = ~cs_sync[1] & cs_sync[2];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state   <= motion_pkg::SPI_IDLE;
      bit_cnt <= '0;
    end else if (cs_fall) begin
      state   <= motion_pkg::SPI_SHIFT;
      bit_cnt <= '0;
    end else begin
      case (state)
        motion_pkg::SPI_SHIFT: begin
          if (cs_rise) begin
            state <= motion_pkg::SPI_IDLE;  // Short frame
          end else if (sck_rise) begin
            bit_cnt <= bit_cnt + 6'd1;
            if (bit_cnt == 6'(`FRAME_BITS - 1))
              state <= motion_pkg::SPI_DONE;
          end
        end
        motion_pkg::SPI_DONE: begin
          // Extra clocks void the frame
          if (cs_rise || sck_rise)
            state <= motion_pkg::SPI_IDLE;
        end
        default: state <= motion_pkg::SPI_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state == motion_pkg::SPI_SHIFT && sck_rise)
      rx_shift <= {rx_shift[`FRAME_BITS-2:0], copi_sync[1]};
  end

  // Position snapshot at CS fall, zeros shift in behind it
  always_ff @(posedge CLK) begin
    if (cs_fall)
      tx_shift <= position;
    else if (state == motion_pkg::SPI_SHIFT && sck_fall && bit_cnt != '0)
      tx_shift <= {tx_shift[30:0], 1'b0};
  end

  assign cipo = (state != motion_pkg::SPI_IDLE) ? tx_shift[31] : 1'b0;

  assign opcode     = rx_shift[`FRAME_BITS-1 -: 8];
  assign frame_ok   = (state == motion_pkg::SPI_DONE) && cs_rise;
  assign move_frame = frame_ok && (opcode == `OP_MOVE);
  assign load_move  = move_frame && !(move_valid && !move_ready);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      move_valid  <= 1'b0;
      enable      <= 1'b0;
      cmd_overrun <= 1'b0;
    end else begin
      if (move_frame) begin
        if (load_move)
          move_valid <= 1'b1;
        else
          cmd_overrun <= 1'b1;  // Record still pending, drop the new one
      end else if (move_ready) begin
        move_valid <= 1'b0;
      end
      if (frame_ok && opcode == `OP_ENABLE)
        enable <= rx_shift[0];
    end
  end

  always_ff @(posedge CLK) begin
    if (load_move)
      move_data <= rx_shift[31:0];
  end

endmodule

// File: rtl/move_fifo.sv
`timescale 1ns/1ns
`include "motion_defines.svh"

module move_fifo (
  input  logic                  CLK,
  input  logic                  resetn,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  motion_pkg::move_rec_t in_data,
  output logic                  out_valid,
  input  logic                  out_ready,
  output motion_pkg::move_rec_t out_data,
  output logic                  buffer_dtr
);

  localparam int DEPTH = `MOVE_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  motion_pkg::move_rec_t mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [PTR_W:0]        count;
  logic                  full;
  logic                  push;
  logic                  pop;

  assign full      = (count == (PTR_W + 1)'(DEPTH));
  assign in_ready  = !full;
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign buffer_dtr = !full;  // Room for at least one more record

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge CLK) begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: rtl/step_generator.sv
`timescale 1ns/1ns
`include "motion_defines.svh"

module step_generator (
  input  logic                  CLK,
  input  logic                  resetn,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  motion_pkg::move_rec_t in_data,
  input  logic                  halt,
  output logic                  step,
  output logic                  dir,
  output logic                  move_done,
  output motion_pkg::position_t position
);

  localparam motion_pkg::step_period_t PULSE_CYCLES = 16'(`STEP_PULSE_CYCLES);
  localparam motion_pkg::step_period_t MIN_PERIOD   = 16'(`MIN_STEP_PERIOD);

  motion_pkg::step_state_t  state;
  motion_pkg::step_count_t  remaining;
  motion_pkg::step_period_t period_q;
  motion_pkg::step_period_t phase;
  logic                     req_dir;
  motion_pkg::step_count_t  req_count;
  motion_pkg::step_period_t req_period;
  logic                     accept;
  logic                     next_rise;

  function automatic motion_pkg::position_t stepped(input motion_pkg::position_t p,
                                                    input logic up);
    return up ? p + 32'sd1 : p - 32'sd1;
  endfunction

  assign req_dir    = in_data[31];
  assign req_count  = in_data[30:16];
  assign req_period = in_data[15:0];

  assign in_ready  = (state == motion_pkg::STEP_IDLE) && !halt;
  assign accept    = in_valid && in_ready;
  assign next_rise = (state == motion_pkg::STEP_GAP) && !halt && (phase == period_q);

  assign step      = (state == motion_pkg::STEP_PULSE);
  assign move_done = (state == motion_pkg::STEP_IDLE) && !in_valid;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state    <= motion_pkg::STEP_IDLE;
      dir      <= 1'b0;
      position <= '0;
    end else begin
      case (state)
        motion_pkg::STEP_IDLE: begin
          if (accept) begin
            dir <= req_dir;
            // Zero count is consumed without a pulse
            if (req_count != '0) begin
              state    <= motion_pkg::STEP_PULSE;
              position <= stepped(position, req_dir);
            end
          end
        end
        motion_pkg::STEP_PULSE: begin
          if (phase == PULSE_CYCLES)
            state <= (remaining == '0) ? motion_pkg::STEP_IDLE : motion_pkg::STEP_GAP;
        end
        motion_pkg::STEP_GAP: begin
          if (next_rise) begin
            state    <= motion_pkg::STEP_PULSE;
            position <= stepped(position, dir);
          end
        end
        default: state <= motion_pkg::STEP_IDLE;
      endcase
    end
  end

  // phase counts clocks since the last step rise
  always_ff @(posedge CLK) begin
    case (state)
      motion_pkg::STEP_IDLE: begin
        if (accept) begin
          remaining <= req_count - 1'b1;
          period_q  <= (req_period < MIN_PERIOD) ? MIN_PERIOD : req_period;
          phase     <= 16'd1;
        end
      end
      motion_pkg::STEP_PULSE: phase <= phase + 1'b1;
      motion_pkg::STEP_GAP: begin
        if (halt) begin
          phase <= '0;  // Period starts over once halt drops
        end else if (next_rise) begin
          phase     <= 16'd1;
          remaining <= remaining - 1'b1;
        end else begin
          phase <= phase + 1'b1;
        end
      end
      default: phase <= '0;
    endcase
  end

endmodule

// File: rtl/motion_core.sv
`timescale 1ns/1ns

module motion_core (
  input  logic CLK,
  input  logic resetn,
  input  logic sck,
  input  logic cs,
  input  logic copi,
  input  logic halt,
  output logic cipo,
  output logic step,
  output logic dir,
  output logic enable,
  output logic buffer_dtr,
  output logic move_done,
  output logic cmd_overrun
);

  logic                  move_valid;
  logic                  move_ready;
  motion_pkg::move_rec_t move_data;
  logic                  fifo_valid;
  logic                  fifo_ready;
  motion_pkg::move_rec_t fifo_data;
  motion_pkg::position_t position;

  spi_cmd_decoder decoder_i (
    .CLK         (CLK),
    .resetn      (resetn),
    .sck         (sck),
    .cs          (cs),
    .copi        (copi),
    .cipo        (cipo),
    .position    (position),     // Readback from the generator
    .move_valid  (move_valid),
    .move_ready  (move_ready),
    .move_data   (move_data),
    .enable      (enable),
    .cmd_overrun (cmd_overrun)
  );

  move_fifo fifo_i (
    .CLK        (CLK),
    .resetn     (resetn),
    .in_valid   (move_valid),
    .in_ready   (move_ready),
    .in_data    (move_data),
    .out_valid  (fifo_valid),
    .out_ready  (fifo_ready),
    .out_data   (fifo_data),
    .buffer_dtr (buffer_dtr)
  );

  step_generator stepgen_i (
    .CLK       (CLK),
    .resetn    (resetn),
    .in_valid  (fifo_valid),
    .in_ready  (fifo_ready),
    .in_data   (fifo_data),
    .halt      (halt),
    .step      (step),
    .dir       (dir),
    .move_done (move_done),
    .position  (position)
  );

endmodule

// File: verification/motion_core_chk.sv
`timescale 1ns/1ns
`include "motion_defines.svh"

module motion_core_chk (
  input logic                  CLK,
  input logic                  resetn,
  input logic                  in_valid,
  input logic                  in_ready,
  input motion_pkg::move_rec_t in_data,
  input logic                  step,
  input logic                  halt
);

  // Offered record must hold until taken
  hold_data: assert property (@(posedge CLK) disable iff (!resetn)
    in_valid && !in_ready |=> in_valid && $stable(in_data))
    else $error("record changed while waiting for ready");

  pulse_width: assert property (@(posedge CLK) disable iff (!resetn)
    $rose(step) |-> step [*`STEP_PULSE_CYCLES] ##1 !step)
    else $error("step high time differs from the pulse width");

  // Halted: offered record stays queued and no new pulse starts
  no_accept_in_halt: assert property (@(posedge CLK) disable iff (!resetn)
    halt |=> !$rose(step) && (!$past(in_valid) || (in_valid && $stable(in_data))))
    else $error("record accepted while halted");

endmodule

bind step_generator motion_core_chk stepgen_chk_i (
  .CLK (CLK), .resetn (resetn), .in_valid (in_valid), .in_ready (in_ready),
  .in_data (in_data), .step (step), .halt (halt)
);

// FIFO input side has no step or halt
bind move_fifo motion_core_chk fifo_chk_i (
  .CLK (CLK), .resetn (resetn), .in_valid (in_valid), .in_ready (in_ready),
  .in_data (in_data), .step (1'b0), .halt (1'b0)
);

// File: verification/motion_core_tb.sv
`timescale 1ns/1ns
`include "motion_defines.svh"

module motion_core_tb;

  logic CLK, resetn, sck, cs, copi, halt;
  logic cipo, step, dir, enable, buffer_dtr, move_done, cmd_overrun;

  integer seed = 15;
  int     error_count = 0;
  int     cycle = 0;
  int     rises = 0;
  int     last_rise, cur_left = 0, cur_per = 0;
  logic   cur_dir, step_q = 1'b0, first_rise, halt_seen = 1'b0;
  int     exp_cnt[$];
  int     exp_per[$];
  logic   exp_dir[$];

  motion_core motion_core_i (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  task automatic value_error(input string msg);
    error_count++;
    $display("ERROR at %0t ns: %s", $time, msg);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic abort_run(input string msg);
    error_count++;
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic tick(input int n);
    repeat (n) @(posedge CLK);
    #2;
  endtask

  // Step monitor on the falling clock edge
  always @(negedge CLK) begin
    cycle++;
    if (step && !step_q) begin
      while (cur_left == 0 && exp_cnt.size() > 0) begin
        cur_left   = exp_cnt.pop_front();
        cur_per    = exp_per.pop_front();
        cur_dir    = exp_dir.pop_front();
        first_rise = 1'b1;
      end
      assert (cur_left > 0) else value_error("step rise with no move expected");
      assert (dir == cur_dir) else value_error($sformatf("dir %0b, expected %0b", dir, cur_dir));
      assert (first_rise || halt_seen || cycle - last_rise == cur_per)
        else value_error($sformatf("step spacing %0d, expected %0d", cycle - last_rise, cur_per));
      first_rise = 1'b0;
      halt_seen  = 1'b0;
      cur_left--;
      last_rise = cycle;
      rises++;
    end
    if (halt)
      halt_seen = 1'b1;
    step_q = step;
  end

  task automatic send_frame(input logic [39:0] frame, output logic [31:0] rdata);
    int gap;
    cs = 1'b0;
    tick(4);
    for (int i = 39; i >= 0; i--) begin
      copi = frame[i];
      tick(4);
      sck = 1'b1;
      if (i >= 8)
        rdata[i-8] = cipo;  // Position comes out MSB first
      tick(4);
      sck = 1'b0;
    end
    tick(4);
    cs   = 1'b1;
    copi = 1'b0;
    gap  = 8 + ($unsigned($random(seed)) % 8);
    tick(gap);
  endtask

  task automatic wait_for_done();
    int n = 0;
    while (move_done !== 1'b1) begin
      tick(1);
      n++;
      if (n > 60000)
        abort_run("Timeout while waiting for move_done");
    end
    assert (cur_left == 0) else value_error("move_done with steps still expected");
    foreach (exp_cnt[k])
      assert (exp_cnt[k] == 0) else value_error("move_done before all moves ran");
  endtask

  task automatic hold_halt(input int n);
    int snap;
    halt = 1'b1;
    tick(1);
    snap = rises;
    repeat (n) begin
      tick(1);
      assert (move_done == 1'b0) else value_error("move_done high during halt");
    end
    assert (rises == snap) else value_error("step rise while halted");
    halt = 1'b0;
  endtask

  // Wait for a pin to reach v, with latency margin
  task automatic expect_pin(input string name, input int v);
    int   n = 0;
    logic val;
    forever begin
      case (name)
        "en":    val = enable;
        "dtr":   val = buffer_dtr;
        default: val = cmd_overrun;
      endcase
      if (val == v[0])
        break;
      if (n == 20)
        value_error($sformatf("%s is %0b, expected %0d", name, val, v));
      tick(1);
      n++;
    end
  endtask

  initial begin
    int          fd;
    string       line, cmd;
    int          a, b, c;
    logic [31:0] rdata;
    sck    = 1'b0;
    cs     = 1'b1;
    copi   = 1'b0;
    halt   = 1'b0;
    resetn = 1'b0;
    repeat (8) @(posedge CLK);
    #2 resetn = 1'b1;
    tick(2);
    assert (step == 0 && enable == 0 && cmd_overrun == 0 && cipo == 0)
      else value_error("outputs not cleared by reset");
    assert (move_done == 1 && buffer_dtr == 1) else value_error("move_done or buffer_dtr low");

    fd = $fopen("verification/motion_tests.txt", "r");
    if (fd == 0)
      abort_run("Could not open the test file");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#")
        continue;
      a = 0;
      b = 0;
      c = 0;
      void'($sscanf(line, "%s %d %d %d", cmd, a, b, c));
      case (cmd)
        "move", "drop": begin
          // Steps can start before the frame task returns
          if (cmd == "move") begin
            exp_dir.push_back(a[0]);
            exp_cnt.push_back(b);
            exp_per.push_back(c < `MIN_STEP_PERIOD ? `MIN_STEP_PERIOD : c);
          end
          send_frame({`OP_MOVE, a[0], b[14:0], c[15:0]}, rdata);
        end
        "raw": begin
          void'($sscanf(line, "%s %h %h", cmd, a, b));
          send_frame({a[7:0], b[31:0]}, rdata);
        end
        "pos": begin
          send_frame(40'h0, rdata);
          assert ($signed(rdata) == a)
            else value_error($sformatf("position %0d, expected %0d", $signed(rdata), a));
        end
        "halt": hold_halt(a);
        "idle": tick(a);
        "wait": wait_for_done();
        "en", "dtr", "ovr": expect_pin(cmd, a);
        default: abort_run({"Unknown command in test file: ", cmd});
      endcase
    end
    $fclose(fd);
    if (error_count == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: verification/motion_tests.txt
# move|drop dir count period, raw opcode_hex data_hex, pos expected, halt cycles
# idle cycles, wait (for move_done), en|dtr|ovr expected pin value
pos 0
move 1 5 20
wait
pos 5
move 0 3 3
wait
pos 2
move 1 8 400
move 0 2 10
move 1 0 10
move 0 3 12
move 1 2 9
move 0 1 8
dtr 0
wait
dtr 1
pos 6
raw 02 00000001
en 1
raw 55 00000000
en 1
raw 02 00000000
en 0
move 1 6 50
idle 80
halt 200
wait
pos 12
move 1 10 400
move 0 2 8
move 0 2 8
move 1 1 8
move 0 1 8
move 0 1 8
drop 1 7 8
ovr 1
wait
pos 17

// File: tb.f
+incdir+rtl
rtl/motion_pkg.sv
rtl/spi_cmd_decoder.sv
rtl/move_fifo.sv
rtl/step_generator.sv
rtl/motion_core.sv
verification/motion_core_chk.sv
verification/motion_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= motion_core_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "Test failed, see $(LOG)"; exit 1; }
	@echo "Test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
